//--- src/cpuPkg.sv
// CPU shared definitions
package cpuPkg;

	localparam int dataBits = 16; // Word and instruction width.
	localparam int regBits = 3; // Register index width.
	localparam int regCount = 8; // Registers in the file.
	localparam logic [regBits-1:0] pcIndex = 3'd7; // Top register is the PC.

	// Instruction opcodes, bits 15 to 12.
	typedef enum logic [3:0] {
		opAdd = 4'h0, // rd = ra + rb.
		opSub = 4'h1, // rd = ra - rb.
		opAnd = 4'h2, // rd = ra & rb.
		opOr = 4'h3, // rd = ra | rb.
		opXor = 4'h4, // rd = ra ^ rb.
		opLdi = 4'h5, // rd = zero-extended imm.
		opLd = 4'h6, // rd = mem[ra].
		opSt = 4'h7, // mem[ra] = rb.
		opInc = 4'h8, // rd = ra + 1.
		opHalt = 4'hF // Stop the core.
	} opcodeT;

	// Bus sequencer states.
	typedef enum logic [2:0] {
		stIdle, // Out of reset.
		stFetch, // Instruction read.
		stExec, // Decode and write-back.
		stMem, // Data read or write.
		stHalted // Parked until reset.
	} stateT;

	typedef struct packed {
		logic [regBits-1:0] aSel; // ALU A operand.
		logic [regBits-1:0] bSel; // ALU B operand.
		logic [regBits-1:0] mSel; // Bus write data.
		logic [regBits-1:0] addrSel; // Bus address.
	} regSelT;

	typedef struct packed {
		logic [regCount-1:0] ldAlu; // Load from ALU result.
		logic [regCount-1:0] ldMem; // Load from bus data.
		logic [regCount-1:0] ldImm; // Load from immediate.
		logic [regCount-1:0] inc; // Increment in place.
	} regLoadT;

	typedef struct packed {
		opcodeT op;
		logic [regBits-1:0] rd;
		logic [regBits-1:0] ra;
		logic [regBits-1:0] rb;
		logic [dataBits-1:0] imm; // Already zero-extended.
	} decodedT;

endpackage

//--- src/registerFile.sv
// Eight-entry register file
`timescale 1ns/1ns

module registerFile #(
	parameter logic [cpuPkg::dataBits-1:0] resetPc = '0 // PC value after reset.
) (
	input logic CLK,
	input logic arstN,
	input logic [cpuPkg::dataBits-1:0] aluIn, // ALU result.
	input logic [cpuPkg::dataBits-1:0] memIn, // Bus read data.
	input logic [cpuPkg::dataBits-1:0] immIn, // Instruction immediate.
	input cpuPkg::regLoadT load, // Per-register strobes.
	input cpuPkg::regSelT sel, // Read port indexes.
	output logic [cpuPkg::dataBits-1:0] aluA,
	output logic [cpuPkg::dataBits-1:0] aluB,
	output logic [cpuPkg::dataBits-1:0] mData,
	output logic [cpuPkg::dataBits-1:0] mAddr
);

	logic [cpuPkg::dataBits-1:0] regs [cpuPkg::regCount]; // Register storage.

	// Each register picks one source per cycle.
	always_ff @(posedge CLK or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < cpuPkg::regCount; i++)
			begin
				if (i == int'(cpuPkg::pcIndex))
					regs[i] <= resetPc; // Start address.
				else
					regs[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < cpuPkg::regCount; i++)
			begin
				if (load.ldMem[i])
					regs[i] <= memIn; // Memory wins.
				else if (load.ldAlu[i])
					regs[i] <= aluIn;
				else if (load.ldImm[i])
					regs[i] <= immIn;
				else if (load.inc[i])
					regs[i] <= regs[i] + 1'b1; // Wraps at 2^16.
			end
		end
	end

	// Combinational read ports.
	assign aluA = regs[sel.aSel]; // Operand A.
	assign aluB = regs[sel.bSel]; // Operand B.
	assign mData = regs[sel.mSel]; // Store data.
	assign mAddr = regs[sel.addrSel]; // PC in fetch, ra otherwise.

endmodule

//--- src/instrDecode.sv
// Instruction decoder
`timescale 1ns/1ns

module instrDecode (
	input logic [cpuPkg::dataBits-1:0] instr, // Instruction register.
	input logic fetching, // Sequencer is in fetch.
	output cpuPkg::decodedT dec,
	output cpuPkg::regSelT sel
);

	cpuPkg::opcodeT op; // Cleaned opcode.

	// Unused codes behave as halt.
	always_comb
	begin
		case (instr[15:12])
			cpuPkg::opAdd,
			cpuPkg::opSub,
			cpuPkg::opAnd,
			cpuPkg::opOr,
			cpuPkg::opXor,
			cpuPkg::opLdi,
			cpuPkg::opLd,
			cpuPkg::opSt,
			cpuPkg::opInc:
				op = cpuPkg::opcodeT'(instr[15:12]); // Known code.
			default:
				op = cpuPkg::opHalt;
		endcase
	end

	// Field split.
	always_comb
	begin
		dec.op = op;
		dec.rd = instr[11:9]; // Destination.
		dec.ra = instr[8:6]; // Source A, also the data address.
		dec.rb = instr[5:3]; // Source B, also the store data.
		dec.imm = {{(cpuPkg::dataBits - 8){1'b0}}, instr[7:0]}; // Zero-extended.
	end

	// Read port selections.
	always_comb
	begin
		sel.aSel = dec.ra;
		sel.bSel = dec.rb;
		sel.mSel = dec.rb; // Store source.
		if (fetching)
			sel.addrSel = cpuPkg::pcIndex; // Fetch from PC.
		else
			sel.addrSel = dec.ra; // Load or store address.
	end

endmodule

//--- src/aluExecute.sv
// Arithmetic and logic unit
`timescale 1ns/1ns

module aluExecute (
	input cpuPkg::decodedT dec, // Decoded instruction.
	input logic [cpuPkg::dataBits-1:0] a, // Operand from ra.
	input logic [cpuPkg::dataBits-1:0] b, // Operand from rb.
	output logic [cpuPkg::dataBits-1:0] result
);

	logic [cpuPkg::dataBits-1:0] sum; // a + b.
	logic [cpuPkg::dataBits-1:0] diff; // a - b.
	logic [cpuPkg::dataBits-1:0] incr; // a + 1.

	// Modulo arithmetic, carries dropped.
	assign sum = a + b;
	assign diff = a - b; // Underflow wraps.
	assign incr = a + 1'b1;

	// Opcode picks the result.
	always_comb
	begin
		case (dec.op)
			cpuPkg::opAdd:
				result = sum;
			cpuPkg::opSub:
				result = diff;
			cpuPkg::opAnd:
				result = a & b;
			cpuPkg::opOr:
				result = a | b;
			cpuPkg::opXor:
				result = a ^ b;
			cpuPkg::opInc:
				result = incr; // rb ignored.
			default:
				result = '0; // Not loaded anywhere.
		endcase
	end

endmodule

//--- src/busResult.sv
// Bus sequencer and write-back
`timescale 1ns/1ns

module busResult (
	input logic CLK,
	input logic arstN,
	input cpuPkg::decodedT dec, // Current instruction fields.
	input logic wbAck,
	input logic [cpuPkg::dataBits-1:0] wbDatI, // Instruction or load data.
	output logic [cpuPkg::dataBits-1:0] instr, // Instruction register.
	output logic fetching,
	output cpuPkg::regLoadT load, // Register strobes.
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output logic halted
);

	cpuPkg::stateT state;
	cpuPkg::stateT nextState;
	logic [cpuPkg::regCount-1:0] rdHot; // One-hot destination.
	logic aluOp; // Result comes from the ALU.

	always_ff @(posedge CLK or negedge arstN)
	begin
		if (!arstN)
			state <= cpuPkg::stIdle;
		else
			state <= nextState;
	end

	// Sequencer.
	always_comb
	begin
		nextState = state;
		case (state)
			cpuPkg::stIdle:
				nextState = cpuPkg::stFetch; // First edge after reset.
			cpuPkg::stFetch:
				if (wbAck)
					nextState = cpuPkg::stExec;
			cpuPkg::stExec:
				case (dec.op)
					cpuPkg::opLd, cpuPkg::opSt:
						nextState = cpuPkg::stMem;
					cpuPkg::opHalt:
						nextState = cpuPkg::stHalted;
					default:
						nextState = cpuPkg::stFetch; // Register ops done.
				endcase
			cpuPkg::stMem:
				if (wbAck)
					nextState = cpuPkg::stFetch;
			default:
				nextState = cpuPkg::stHalted; // Stays until reset.
		endcase
	end

	// Capture on fetch ack.
	always_ff @(posedge CLK)
	begin
		if (fetching && wbAck)
			instr <= wbDatI;
	end

	// Bus controls straight from state.
	assign fetching = (state == cpuPkg::stFetch);
	assign wbCyc = fetching || (state == cpuPkg::stMem);
	assign wbStb = wbCyc; // Classic cycle, one strobe per cycle.
	assign wbWe = (state == cpuPkg::stMem) && (dec.op == cpuPkg::opSt);
	assign halted = (state == cpuPkg::stHalted);

	assign aluOp = dec.op inside {cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd,
		cpuPkg::opOr, cpuPkg::opXor, cpuPkg::opInc};

	// Write-back strobes.
	always_comb
	begin
		rdHot = '0;
		rdHot[dec.rd] = 1'b1;
		load = '0;
		load.inc[cpuPkg::pcIndex] = fetching && wbAck; // PC step at fetch ack.
		if (state == cpuPkg::stExec && aluOp)
			load.ldAlu = rdHot;
		if (state == cpuPkg::stExec && dec.op == cpuPkg::opLdi)
			load.ldImm = rdHot;
		if (state == cpuPkg::stMem && wbAck && dec.op == cpuPkg::opLd)
			load.ldMem = rdHot; // Load data at ack.
	end

endmodule

//--- src/cpuTop.sv
// Register machine core
`timescale 1ns/1ns

module cpuTop #(
	parameter logic [cpuPkg::dataBits-1:0] resetPc = '0 // First fetch address.
) (
	input logic CLK,
	input logic arstN,
	input logic [cpuPkg::dataBits-1:0] wbDatI,
	input logic wbAck,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output logic [cpuPkg::dataBits-1:0] wbAdr,
	output logic [cpuPkg::dataBits-1:0] wbDatO,
	output logic halted
);

	logic [cpuPkg::dataBits-1:0] instr; // Instruction register.
	logic fetching;
	cpuPkg::decodedT dec;
	cpuPkg::regSelT sel;
	cpuPkg::regLoadT load;
	logic [cpuPkg::dataBits-1:0] aluA;
	logic [cpuPkg::dataBits-1:0] aluB;
	logic [cpuPkg::dataBits-1:0] aluResult;

	registerFile #(
		.resetPc(resetPc)
	) regFileInst (
		.CLK(CLK),
		.arstN(arstN),
		.aluIn(aluResult),
		.memIn(wbDatI), // Loads straight off the bus.
		.immIn(dec.imm),
		.load(load),
		.sel(sel),
		.aluA(aluA),
		.aluB(aluB),
		.mData(wbDatO), // Store data.
		.mAddr(wbAdr) // Bus address.
	);

	instrDecode decodeInst (.instr(instr), .fetching(fetching), .dec(dec), .sel(sel));

	aluExecute aluInst (.dec(dec), .a(aluA), .b(aluB), .result(aluResult));

	busResult seqInst (
		.CLK(CLK),
		.arstN(arstN),
		.dec(dec),
		.wbAck(wbAck),
		.wbDatI(wbDatI),
		.instr(instr),
		.fetching(fetching),
		.load(load),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.halted(halted)
	);

endmodule

//--- testbench/cpuBus_props.sv
// Wishbone master port checks
`timescale 1ns/1ns

module cpuBusProps (
	input logic CLK,
	input logic arstN,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic wbAck,
	input logic halted,
	input logic [cpuPkg::dataBits-1:0] wbAdr,
	input logic [cpuPkg::dataBits-1:0] wbDatO
);

	stbInCyc: assert property (@(posedge CLK) disable iff (!arstN) wbStb |-> wbCyc)
		else $error("wbStb raised outside a bus cycle");

	// Stalled request keeps its outputs.
	holdReq: assert property (@(posedge CLK) disable iff (!arstN)
		(wbCyc && wbStb && !wbAck) |=> (wbCyc && wbStb && $stable(wbAdr)
		&& $stable(wbWe) && $stable(wbDatO)))
		else $error("request changed before wbAck");

	noReqHalted: assert property (@(posedge CLK) disable iff (!arstN)
		halted |-> !(wbCyc || wbStb))
		else $error("bus request while halted");

endmodule

bind cpuTop cpuBusProps busPropsInst (.CLK(CLK), .arstN(arstN), .wbCyc(wbCyc),
	.wbStb(wbStb), .wbWe(wbWe), .wbAck(wbAck), .halted(halted), .wbAdr(wbAdr),
	.wbDatO(wbDatO));

//--- testbench/cpuTb.sv
// Core testbench with memory model
`timescale 1ns/1ns

module cpuTb;

	localparam int clkPeriod = 4; // In ns.
	localparam int resetCycles = 10;
	localparam int cyclesPerWord = 20; // Watchdog budget per program word.
	localparam logic [15:0] startPc = 16'd16; // Program origin.

	logic CLK;
	logic arstN;
	logic [15:0] wbDatI;
	logic wbAck;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [15:0] wbAdr;
	logic [15:0] wbDatO;
	logic halted;
	logic [15:0] mem [256]; // Word memory.
	logic [15:0] expAdr [8]; // Store table.
	logic [15:0] expDat [8];
	logic [15:0] expPc = startPc; // Next fetch address.
	logic dataNext = 1'b0; // Last fetch was a load or store.
	int storeCount = 0;
	int storeIdx = 0;
	int fetchCount = 0;
	int progWords = 0;
	int checks = 0;
	int errors = 0;

	cpuTop #(.resetPc(startPc)) dut_i (.CLK(CLK), .arstN(arstN), .wbDatI(wbDatI),
		.wbAck(wbAck), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatO(wbDatO), .halted(halted));

	task automatic checkValue(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	// Completes the pending transfer and raises ack.
	task automatic serveRequest();
		if (!dataNext)
		begin
			checkValue("fetch wbAdr", wbAdr, expPc);
			checkValue("fetch wbWe", 16'(wbWe), 16'd0);
			expPc = expPc + 16'd1; // Strictly sequential.
			fetchCount++;
			wbDatI = mem[wbAdr[7:0]];
			dataNext = (wbDatI[15:12] == cpuPkg::opLd) || (wbDatI[15:12] == cpuPkg::opSt);
		end
		else if (wbWe)
		begin
			dataNext = 1'b0;
			if (storeIdx < storeCount)
			begin
				checkValue("store wbAdr", wbAdr, expAdr[storeIdx]);
				checkValue("store wbDatO", wbDatO, expDat[storeIdx]);
			end
			else
			begin
				errors++;
				$display("unexpected store at %0t ns past the end of the table", $time);
			end
			storeIdx++;
			mem[wbAdr[7:0]] = wbDatO;
		end
		else
		begin
			dataNext = 1'b0;
			wbDatI = mem[wbAdr[7:0]]; // Load data.
		end
		wbAck = 1'b1;
	endtask

	initial
	begin
		CLK = 1'b0;
		forever
			#(clkPeriod / 2) CLK = ~CLK;
	end

	// Slave side, random wait states.
	initial
	begin
		int waitLeft;
		logic busy;
		void'($urandom(17792)); // Fixed seed.
		waitLeft = 0;
		busy = 1'b0;
		wbAck = 1'b0;
		wbDatI = '0;
		forever
		begin
			@(posedge CLK);
			#1;
			if (wbAck)
			begin
				wbAck = 1'b0; // Consumed at this edge.
				busy = 1'b0;
			end
			if (!busy && wbCyc && wbStb)
			begin
				busy = 1'b1;
				waitLeft = int'($urandom % 4); // 0 to 3 wait cycles.
			end
			else if (busy)
				waitLeft--;
			if (busy && waitLeft == 0)
				serveRequest();
		end
	end

	initial
	begin
		arstN = 1'b0;
		for (int i = 0; i < 256; i++)
			mem[i] = {8'(i), ~8'(i)}; // Unwritten words stand out.
		$readmemh("testbench/cpuTestdata.hex", mem);
		storeCount = (int'(mem[0]) > 8) ? 8 : int'(mem[0]); // Room for 8 pairs.
		for (int i = 0; i < storeCount; i++)
		begin
			expAdr[i] = mem[2 * i + 1];
			expDat[i] = mem[2 * i + 2];
		end
		while (progWords < 239 && mem[16 + progWords][15:12] != cpuPkg::opHalt)
			progWords++;
		progWords++; // Halt word included.
		repeat (resetCycles) @(posedge CLK);
		#1;
		checkValue("wbCyc in reset", 16'(wbCyc), 16'd0);
		checkValue("wbStb in reset", 16'(wbStb), 16'd0);
		checkValue("halted in reset", 16'(halted), 16'd0);
		arstN = 1'b1; // Fetch starts next edge.
		while (!halted)
		begin
			@(posedge CLK);
			#1;
		end
		repeat (8)
		begin
			@(posedge CLK);
			#1;
			checkValue("wbCyc after halt", 16'(wbCyc), 16'd0);
			checkValue("wbStb after halt", 16'(wbStb), 16'd0);
			checkValue("halted", 16'(halted), 16'd1);
		end
		checkValue("store count", 16'(storeIdx), 16'(storeCount));
		checkValue("fetch count", 16'(fetchCount), 16'(progWords));
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// Watchdog, scaled by program length.
	initial
	begin
		@(posedge arstN);
		#(progWords * cyclesPerWord * clkPeriod);
		$display("timeout at %0t ns because the core never halted", $time);
		$display("tests failed");
		$finish;
	end

endmodule

//--- testbench/cpuTestdata.hex
// Word 0 is the store count, words 1 to 14 are store address and data pairs.
// Program words start at 10 hex, three per line; word F0 is the preset load data.
@00
0007
0080 FFE2 0081 003C 0082 0018
0083 007E 0084 0066 0085 8001
0086 005A
@10
525A 543C 5080 // LDI r1 5A, LDI r2 3C, LDI r0 80
1888 7020 8000 // SUB r4 r2 r1 underflow, ST [r0] r4, INC r0
0708 7018 8000 // ADD r3 r4 r1 wraps, ST [r0] r3, INC r0
2650 7018 8000 // AND r3 r1 r2, ST [r0] r3, INC r0
3650 7018 8000 // OR r3 r1 r2, ST [r0] r3, INC r0
4650 7018 8000 // XOR r3 r1 r2, ST [r0] r3, INC r0
5AF0 6D40 7030 // LDI r5 F0, LD r6 [r5], ST [r0] r6
8000 7008 F000 // INC r0, ST [r0] r1, HALT
@F0
8001

//--- list.f
src/cpuPkg.sv
src/registerFile.sv
src/instrDecode.sv
src/aluExecute.sv
src/busResult.sv
src/cpuTop.sv
testbench/cpuBus_props.sv
testbench/cpuTb.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module cpuTb -o cpuSim
./obj_dir/cpuSim | tee sim.log
if grep -qx "all tests passed" sim.log
then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
